//--- verification/axil_sram_stim.txt
# op addr data strb exp_rdata exp_resp, all hex
# op W write, R read, B write and read together; resp 0 OKAY, 2 SLVERR
W 00000010 0123456789abcdef ff 0000000000000000 0
R 00000010 0000000000000000 00 0123456789abcdef 0
W 00000020 ffffffffffffffff ff 0000000000000000 0
W 00000020 1122334455667788 0f 0000000000000000 0
R 00000020 0000000000000000 00 ffffffff55667788 0
W 00000028 ffffffffffffffff ff 0000000000000000 0
W 00000028 a5a5a5a5a5a5a5a5 81 0000000000000000 0
R 00000028 0000000000000000 00 a5ffffffffffffa5 0
W 00000030 ffffffffffffffff ff 0000000000000000 0
W 00000030 0000000000000000 3c 0000000000000000 0
R 00000030 0000000000000000 00 ffff00000000ffff 0
W 00000820 deadbeefdeadbeef ff 0000000000000000 2
R 00000820 0000000000000000 00 0000000000000000 2
R 00000020 0000000000000000 00 ffffffff55667788 0
R 80000000 0000000000000000 00 0000000000000000 2
W 00000100 cafef00d12345678 ff 0000000000000000 0
R 00000100 0000000000000000 00 cafef00d12345678 0
W 000007f8 0f0e0d0c0b0a0908 ff 0000000000000000 0
R 000007f8 0000000000000000 00 0f0e0d0c0b0a0908 0
B 00000040 fedcba9876543210 ff fedcba9876543210 0
B 00000100 0000000000000000 f0 0000000012345678 0
R 00000040 0000000000000000 00 fedcba9876543210 0

//--- axil_sram.f
+incdir+hdl
hdl/axil_sram_pkg.sv
hdl/data_sram.sv
hdl/axil_sram_slave.sv
hdl/axil_sram_top.sv
verification/axil_sram_checker.sv
verification/axil_sram_tb.sv

//--- Bender.yml
package:
  name: axil_sram

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/axil_sram_pkg.sv
      - hdl/data_sram.sv
      - hdl/axil_sram_slave.sv
      - hdl/axil_sram_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verification/axil_sram_checker.sv
      - verification/axil_sram_tb.sv

//--- verification/axil_sram_tb.sv
// Testbench for the AXI-Lite data memory, replays the stimulus file and checks every response
`include "axil_sram_settings.svh"

module axil_sram_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT   = 40;
  localparam int MAX_DELAY = 6;

  logic                        clk;
  logic                        rst;
  axil_sram_pkg::axil_aw_t     aw;
  logic                        aw_valid;
  logic                        aw_ready;
  axil_sram_pkg::axil_w_t      w;
  logic                        w_valid;
  logic                        w_ready;
  axil_sram_pkg::axil_b_t      b;
  logic                        b_valid;
  logic                        b_ready;
  axil_sram_pkg::axil_ar_t     ar;
  logic                        ar_valid;
  logic                        ar_ready;
  axil_sram_pkg::axil_r_t      r;
  logic                        r_valid;
  logic                        r_ready;

  integer seed;
  int     errors;
  int     tests;
  int     cycle;
  int     b_rise;
  int     r_rise;
  logic   b_valid_d;
  logic   r_valid_d;
  bit     timed_out;

  axil_sram_top dut (
    .clk        (clk),
    .rst        (rst),
    .i_aw       (aw),
    .i_aw_valid (aw_valid),
    .o_aw_ready (aw_ready),
    .i_w        (w),
    .i_w_valid  (w_valid),
    .o_w_ready  (w_ready),
    .o_b        (b),
    .o_b_valid  (b_valid),
    .i_b_ready  (b_ready),
    .i_ar       (ar),
    .i_ar_valid (ar_valid),
    .o_ar_ready (ar_ready),
    .o_r        (r),
    .o_r_valid  (r_valid),
    .i_r_ready  (r_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Cycle stamps of the latest B and R valid rises, used for the write-first order
  always @(posedge clk) begin
    cycle     <= cycle + 1;
    b_valid_d <= b_valid;
    r_valid_d <= r_valid;
    b_rise    <= (b_valid && !b_valid_d) ? cycle : b_rise;
    r_rise    <= (r_valid && !r_valid_d) ? cycle : r_rise;
  end

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("ERR %s expected %h actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: %s did not arrive within %0d cycles", what, TIMEOUT);
    errors++;
    timed_out = 1'b1;
  endtask

  task automatic write_txn(input logic [31:0] addr, input logic [`AXIL_DATA_WIDTH-1:0] data,
                           input logic [`AXIL_STRB_WIDTH-1:0] strb, output logic [1:0] resp);
    int         count;
    int         delay;
    logic [1:0] held;
    resp     = 2'bxx;
    aw.addr  <= addr;
    aw.prot  <= 3'b000;
    aw_valid <= 1'b1;
    w.data   <= data;
    w.strb   <= strb;
    w_valid  <= 1'b1;
    count = 0;
    do begin
      @(posedge clk);
      count++;
    end while (!(aw_ready && w_ready) && count < TIMEOUT);
    aw_valid <= 1'b0;
    w_valid  <= 1'b0;
    if (!(aw_ready && w_ready)) begin
      report_timeout("AW/W ready");
      return;
    end
    // Hold off B for a while, the response must not move meanwhile
    held  = b.resp;
    delay = {$random(seed)} % (MAX_DELAY + 1);
    check_value("b_valid", 1, b_valid);
    repeat (delay) begin
      @(posedge clk);
      check_value("b_valid", 1, b_valid);
      check_value("b.resp", held, b.resp);
    end
    b_ready <= 1'b1;
    count = 0;
    do begin
      @(posedge clk);
      count++;
    end while (!b_valid && count < TIMEOUT);
    b_ready <= 1'b0;
    if (!b_valid) begin
      report_timeout("B valid");
      return;
    end
    resp = b.resp;
  endtask

  task automatic read_txn(input logic [31:0] addr, output logic [`AXIL_DATA_WIDTH-1:0] data,
                          output logic [1:0] resp);
    int                          count;
    int                          delay;
    logic [`AXIL_DATA_WIDTH-1:0] held_data;
    logic [1:0]                  held_resp;
    data     = 'x;
    resp     = 2'bxx;
    ar.addr  <= addr;
    ar.prot  <= 3'b000;
    ar_valid <= 1'b1;
    count = 0;
    do begin
      @(posedge clk);
      count++;
    end while (!ar_ready && count < TIMEOUT);
    ar_valid <= 1'b0;
    if (!ar_ready) begin
      report_timeout("AR ready");
      return;
    end
    held_data = r.data;
    held_resp = r.resp;
    delay     = {$random(seed)} % (MAX_DELAY + 1);
    check_value("r_valid", 1, r_valid);
    repeat (delay) begin
      @(posedge clk);
      check_value("r_valid", 1, r_valid);
      check_value("r.data", held_data, r.data);
      check_value("r.resp", held_resp, r.resp);
    end
    r_ready <= 1'b1;
    count = 0;
    do begin
      @(posedge clk);
      count++;
    end while (!r_valid && count < TIMEOUT);
    r_ready <= 1'b0;
    if (!r_valid) begin
      report_timeout("R valid");
      return;
    end
    data = r.data;
    resp = r.resp;
  endtask

  task automatic run_line(input byte op, input logic [31:0] addr,
                          input logic [`AXIL_DATA_WIDTH-1:0] data,
                          input logic [`AXIL_STRB_WIDTH-1:0] strb,
                          input logic [`AXIL_DATA_WIDTH-1:0] exp_data,
                          input logic [1:0] exp_resp);
    int                          errors_before;
    logic [1:0]                  wresp;
    logic [1:0]                  rresp;
    logic [`AXIL_DATA_WIDTH-1:0] rdata;
    errors_before = errors;
    tests++;
    case (op)
      "W": begin
        write_txn(addr, data, strb, wresp);
        check_value("b.resp", exp_resp, wresp);
      end
      "R": begin
        read_txn(addr, rdata, rresp);
        check_value("r.data", exp_data, rdata);
        check_value("r.resp", exp_resp, rresp);
      end
      "B": begin
        fork
          write_txn(addr, data, strb, wresp);
          read_txn(addr, rdata, rresp);
        join
        check_value("b.resp", exp_resp, wresp);
        check_value("r.data", exp_data, rdata);
        check_value("r.resp", exp_resp, rresp);
        check_value("b_valid_leads_r_valid", 1, b_rise <= r_rise);
      end
      default: begin
        $display("Unknown operation '%c' in stimulus file", op);
        errors++;
      end
    endcase
    $display("test %0d %c addr %h: %s", tests, op, addr,
             (errors == errors_before) ? "ok" : "failed");
  endtask

  initial begin
    int                          fd;
    int                          code;
    string                       line;
    byte                         op;
    logic [31:0]                 addr;
    logic [`AXIL_DATA_WIDTH-1:0] data;
    logic [`AXIL_DATA_WIDTH-1:0] exp_data;
    logic [`AXIL_STRB_WIDTH-1:0] strb;
    logic [1:0]                  exp_resp;
    seed      = 62;
    errors    = 0;
    tests     = 0;
    timed_out = 1'b0;
    rst       = 1'b1;
    aw        = '0;
    aw_valid  = 1'b0;
    w         = '0;
    w_valid   = 1'b0;
    b_ready   = 1'b0;
    ar        = '0;
    ar_valid  = 1'b0;
    r_ready   = 1'b0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    tests++;
    check_value("aw_ready", 0, aw_ready);
    check_value("w_ready", 0, w_ready);
    check_value("b_valid", 0, b_valid);
    check_value("ar_ready", 0, ar_ready);
    check_value("r_valid", 0, r_valid);
    $display("test %0d reset outputs: %s", tests, (errors == 0) ? "ok" : "failed");

    fd = $fopen("verification/axil_sram_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file");
      errors++;
    end else begin
      while (!$feof(fd) && !timed_out) begin
        line = "";
        code = $fgets(line, fd);
        if (code > 0 && line.len() > 1 && line[0] != "#") begin
          code = $sscanf(line, "%c %h %h %h %h %h", op, addr, data, strb, exp_data, exp_resp);
          if (code == 6) begin
            run_line(op, addr, data, strb, exp_data, exp_resp);
          end else begin
            $display("Malformed stimulus line: %s", line);
            errors++;
          end
        end
      end
      $fclose(fd);
    end

    repeat (2) @(posedge clk);
    if (dut.u_slave.u_checker.assert_failures != 0) begin
      $display("Protocol assertions failed %0d times", dut.u_slave.u_checker.assert_failures);
      errors += dut.u_slave.u_checker.assert_failures;
    end
    $display("Tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- verification/axil_sram_checker.sv
// AXI-Lite protocol assertions that the bind below attaches to every slave instance
module axil_sram_checker (
  input logic                   clk,
  input logic                   rst,
  input logic                   i_aw_ready,
  input logic                   i_w_ready,
  input logic                   i_ar_ready,
  input axil_sram_pkg::axil_b_t i_b,
  input logic                   i_b_valid,
  input logic                   i_b_ready,
  input axil_sram_pkg::axil_r_t i_r,
  input logic                   i_r_valid,
  input logic                   i_r_ready
);
  timeunit 1ns;
  timeprecision 1ps;

  // Failure count that the testbench top reads at the end of the run
  int assert_failures = 0;

  // Valid holds with a stable payload until the master takes it
  b_hold: assert property (@(posedge clk) disable iff (rst)
    (i_b_valid && !i_b_ready) |=> (i_b_valid && $stable(i_b)))
    else begin
      $error("B response dropped or changed before b_ready");
      assert_failures++;
    end

  r_hold: assert property (@(posedge clk) disable iff (rst)
    (i_r_valid && !i_r_ready) |=> (i_r_valid && $stable(i_r)))
    else begin
      $error("R response dropped or changed before r_ready");
      assert_failures++;
    end

  // Write ready is a one-cycle pulse on both channels that comes with the B response
  aw_w_pair: assert property (@(posedge clk) disable iff (rst)
    (i_aw_ready || i_w_ready) |-> (i_aw_ready && i_w_ready && i_b_valid))
    else begin
      $error("aw_ready and w_ready not raised together with b_valid");
      assert_failures++;
    end

  aw_pulse: assert property (@(posedge clk) disable iff (rst)
    i_aw_ready |=> !i_aw_ready)
    else begin
      $error("aw_ready held for more than one cycle");
      assert_failures++;
    end

  reset_quiet: assert property (@(posedge clk)
    rst |=> !(i_aw_ready || i_w_ready || i_ar_ready || i_b_valid || i_r_valid))
    else begin
      $error("Ready or valid high during reset");
      assert_failures++;
    end

endmodule

bind axil_sram_slave axil_sram_checker u_checker (
  .clk        (clk),
  .rst        (rst),
  .i_aw_ready (o_aw_ready),
  .i_w_ready  (o_w_ready),
  .i_ar_ready (o_ar_ready),
  .i_b        (o_b),
  .i_b_valid  (o_b_valid),
  .i_b_ready  (i_b_ready),
  .i_r        (o_r),
  .i_r_valid  (o_r_valid),
  .i_r_ready  (i_r_ready)
);

//--- hdl/axil_sram_top.sv
// Top level of the AXI-Lite data memory, exposes the slave port and holds the SRAM
`include "axil_sram_settings.svh"

module axil_sram_top (
  input  logic                      clk,
  input  logic                      rst,

  input  axil_sram_pkg::axil_aw_t   i_aw,
  input  logic                      i_aw_valid,
  output logic                      o_aw_ready,

  input  axil_sram_pkg::axil_w_t    i_w,
  input  logic                      i_w_valid,
  output logic                      o_w_ready,

  output axil_sram_pkg::axil_b_t    o_b,
  output logic                      o_b_valid,
  input  logic                      i_b_ready,

  input  axil_sram_pkg::axil_ar_t   i_ar,
  input  logic                      i_ar_valid,
  output logic                      o_ar_ready,

  output axil_sram_pkg::axil_r_t    o_r,
  output logic                      o_r_valid,
  input  logic                      i_r_ready
);

  axil_sram_pkg::sram_req_t    sram_req;
  logic [`AXIL_DATA_WIDTH-1:0] sram_rdata;

  axil_sram_slave u_slave (
    .clk          (clk),
    .rst          (rst),
    .i_aw         (i_aw),
    .i_aw_valid   (i_aw_valid),
    .o_aw_ready   (o_aw_ready),
    .i_w          (i_w),
    .i_w_valid    (i_w_valid),
    .o_w_ready    (o_w_ready),
    .o_b          (o_b),
    .o_b_valid    (o_b_valid),
    .i_b_ready    (i_b_ready),
    .i_ar         (i_ar),
    .i_ar_valid   (i_ar_valid),
    .o_ar_ready   (o_ar_ready),
    .o_r          (o_r),
    .o_r_valid    (o_r_valid),
    .i_r_ready    (i_r_ready),
    .o_sram_req   (sram_req),
    .i_sram_rdata (sram_rdata)
  );

  data_sram #(
    .DEPTH (2 ** `SRAM_ADDR_WD)
  ) u_sram (
    .clk     (clk),
    .i_req   (sram_req),
    .o_rdata (sram_rdata)
  );

endmodule

//--- hdl/axil_sram_slave.sv
// AXI4-Lite slave that turns single write or read transfers into SRAM requests, write first
`include "axil_sram_settings.svh"

module axil_sram_slave (
  input  logic                          clk,
  input  logic                          rst,

  input  axil_sram_pkg::axil_aw_t       i_aw,
  input  logic                          i_aw_valid,
  output logic                          o_aw_ready,

  input  axil_sram_pkg::axil_w_t        i_w,
  input  logic                          i_w_valid,
  output logic                          o_w_ready,

  output axil_sram_pkg::axil_b_t        o_b,
  output logic                          o_b_valid,
  input  logic                          i_b_ready,

  input  axil_sram_pkg::axil_ar_t       i_ar,
  input  logic                          i_ar_valid,
  output logic                          o_ar_ready,

  output axil_sram_pkg::axil_r_t        o_r,
  output logic                          o_r_valid,
  input  logic                          i_r_ready,

  output axil_sram_pkg::sram_req_t      o_sram_req,
  input  logic [`AXIL_DATA_WIDTH-1:0]   i_sram_rdata
);

  // First address bit above the word index
  localparam int RANGE_LSB = `SRAM_BYTE_OFS + `SRAM_ADDR_WD;

  axil_sram_pkg::wr_state_e  wr_state;
  axil_sram_pkg::rd_state_e  rd_state;
  axil_sram_pkg::axil_resp_e b_resp_q;
  axil_sram_pkg::axil_resp_e r_resp_q;

  logic                      wr_ready_q;
  logic                      ar_ready_q;
  logic                      wr_accept;
  logic                      rd_accept;
  logic                      aw_oor;
  logic                      ar_oor;
  logic [`SRAM_ADDR_WD-1:0]  aw_idx;
  logic [`SRAM_ADDR_WD-1:0]  ar_idx;

  // Address decode, anything with upper bits set lies past the array
  assign aw_idx = i_aw.addr[`SRAM_BYTE_OFS +: `SRAM_ADDR_WD];
  assign ar_idx = i_ar.addr[`SRAM_BYTE_OFS +: `SRAM_ADDR_WD];
  assign aw_oor = |i_aw.addr[`AXIL_ADDR_WIDTH-1:RANGE_LSB];
  assign ar_oor = |i_ar.addr[`AXIL_ADDR_WIDTH-1:RANGE_LSB];

  // Write needs both AW and W, and waits for the previous B to be taken
  assign wr_accept = i_aw_valid && i_w_valid &&
                     (wr_state == axil_sram_pkg::WR_IDLE) && !wr_ready_q;

  // Read yields the SRAM port to a write issued in the same cycle
  assign rd_accept = i_ar_valid && (rd_state == axil_sram_pkg::RD_IDLE) &&
                     !ar_ready_q && !o_sram_req.wen;

  // SRAM request
  assign o_sram_req.wen   = wr_accept && !aw_oor;
  assign o_sram_req.ren   = rd_accept && !ar_oor;
  assign o_sram_req.idx   = o_sram_req.wen ? aw_idx : ar_idx;
  assign o_sram_req.wmask = i_w.strb;
  assign o_sram_req.wdata = i_w.data;

  // Write channel FSM and ready pulse
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_state   <= axil_sram_pkg::WR_IDLE;
      wr_ready_q <= 1'b0;
    end else begin
      wr_ready_q <= wr_accept;
      case (wr_state)
        axil_sram_pkg::WR_IDLE: begin
          if (wr_accept) begin
            wr_state <= axil_sram_pkg::WR_RESP;
          end
        end
        axil_sram_pkg::WR_RESP: begin
          if (i_b_ready) begin
            wr_state <= axil_sram_pkg::WR_IDLE;
          end
        end
        default: wr_state <= axil_sram_pkg::WR_IDLE;
      endcase
    end
  end

  // Read channel FSM and ready pulse
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_state   <= axil_sram_pkg::RD_IDLE;
      ar_ready_q <= 1'b0;
    end else begin
      ar_ready_q <= rd_accept;
      case (rd_state)
        axil_sram_pkg::RD_IDLE: begin
          if (rd_accept) begin
            rd_state <= axil_sram_pkg::RD_RESP;
          end
        end
        axil_sram_pkg::RD_RESP: begin
          if (i_r_ready) begin
            rd_state <= axil_sram_pkg::RD_IDLE;
          end
        end
        default: rd_state <= axil_sram_pkg::RD_IDLE;
      endcase
    end
  end

  // Response codes, captured at accept
  always_ff @(posedge clk) begin
    if (wr_accept) begin
      b_resp_q <= aw_oor ? axil_sram_pkg::RESP_SLVERR : axil_sram_pkg::RESP_OKAY;
    end
    if (rd_accept) begin
      r_resp_q <= ar_oor ? axil_sram_pkg::RESP_SLVERR : axil_sram_pkg::RESP_OKAY;
    end
  end

  assign o_aw_ready = wr_ready_q;
  assign o_w_ready  = wr_ready_q;
  assign o_ar_ready = ar_ready_q;

  assign o_b_valid  = (wr_state == axil_sram_pkg::WR_RESP);
  assign o_b.resp   = b_resp_q;

  // SRAM output holds while RD_RESP, so R payload is stable under back-pressure
  assign o_r_valid  = (rd_state == axil_sram_pkg::RD_RESP);
  assign o_r.resp   = r_resp_q;
  assign o_r.data   = (r_resp_q == axil_sram_pkg::RESP_SLVERR) ? '0 : i_sram_rdata;

endmodule

//--- hdl/data_sram.sv
// Single-port synchronous SRAM with byte write mask and registered read data, fed by the slave
`include "axil_sram_settings.svh"

module data_sram #(
  parameter int DEPTH = 2 ** `SRAM_ADDR_WD
) (
  input  logic                          clk,
  input  axil_sram_pkg::sram_req_t      i_req,
  output logic [`AXIL_DATA_WIDTH-1:0]   o_rdata
);

  localparam int BYTE_W = `AXIL_DATA_WIDTH / `AXIL_STRB_WIDTH;

  logic [`AXIL_DATA_WIDTH-1:0] mem [DEPTH];
  logic                        in_range;

  // A smaller array ignores indices past its end
  assign in_range = (int'(i_req.idx) < DEPTH);

  // Byte lanes are written only where the mask bit is set
  always_ff @(posedge clk) begin
    if (i_req.wen && in_range) begin
      for (int b = 0; b < `AXIL_STRB_WIDTH; b++) begin
        if (i_req.wmask[b]) begin
          mem[i_req.idx][b*BYTE_W +: BYTE_W] <= i_req.wdata[b*BYTE_W +: BYTE_W];
        end
      end
    end
  end

  // Read data stays put until the next read strobe
  always_ff @(posedge clk) begin
    if (i_req.ren) begin
      if (in_range) begin
        o_rdata <= mem[i_req.idx];
      end else begin
        o_rdata <= '0;
      end
    end
  end

endmodule

//--- hdl/axil_sram_pkg.sv
// Channel structs, SRAM request struct and enums shared by the AXI-Lite data memory
`include "axil_sram_settings.svh"

package axil_sram_pkg;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2
  } axil_resp_e;

  typedef enum logic {
    RD_IDLE,
    RD_RESP
  } rd_state_e;

  typedef enum logic {
    WR_IDLE,
    WR_RESP
  } wr_state_e;

  typedef struct packed {
    logic [`AXIL_ADDR_WIDTH-1:0] addr;
    logic [2:0]                  prot;
  } axil_aw_t;

  typedef struct packed {
    logic [`AXIL_DATA_WIDTH-1:0] data;
    logic [`AXIL_STRB_WIDTH-1:0] strb;
  } axil_w_t;

  typedef struct packed {
    axil_resp_e resp;
  } axil_b_t;

  typedef struct packed {
    logic [`AXIL_ADDR_WIDTH-1:0] addr;
    logic [2:0]                  prot;
  } axil_ar_t;

  typedef struct packed {
    logic [`AXIL_DATA_WIDTH-1:0] data;
    axil_resp_e                  resp;
  } axil_r_t;

  // Single-cycle strobe, at most one of wen and ren is set
  typedef struct packed {
    logic                        wen;
    logic                        ren;
    logic [`SRAM_ADDR_WD-1:0]    idx;
    logic [`AXIL_STRB_WIDTH-1:0] wmask;
    logic [`AXIL_DATA_WIDTH-1:0] wdata;
  } sram_req_t;

endpackage

//--- hdl/axil_sram_settings.svh
// Bus widths and SRAM geometry for the AXI-Lite data memory, included by the package and RTL
`ifndef AXIL_SRAM_SETTINGS_SVH
`define AXIL_SRAM_SETTINGS_SVH

// AXI4-Lite bus
`define AXIL_DATA_WIDTH 64
`define AXIL_ADDR_WIDTH 32
`define AXIL_STRB_WIDTH 8

// Word index width, 256 words
`define SRAM_ADDR_WD 8

// Byte offset bits inside one 64-bit word
`define SRAM_BYTE_OFS 3

`endif
